//--- hw/car_pkg.sv
package car_pkg;

    // Three reflective sensors, 1 means the sensor sees the line
    typedef struct packed {
        logic left;
        logic mid;
        logic right;
    } line_sensors_t;

    // FOLLOW modes carry the raw pattern {0, left, mid, right}
    typedef enum logic [3:0] {
        FOLLOW_000 = 4'b0000,
        FOLLOW_001 = 4'b0001,
        FOLLOW_010 = 4'b0010,
        FOLLOW_011 = 4'b0011,
        FOLLOW_100 = 4'b0100,
        FOLLOW_101 = 4'b0101,
        FOLLOW_110 = 4'b0110,
        FOLLOW_111 = 4'b0111,
        STAY_L     = 4'b1000,
        STAY_R     = 4'b1001
    } track_mode_t;

    // Motor duty
    localparam int DUTY_W = 10;

    typedef struct packed {
        logic [DUTY_W-1:0] left;
        logic [DUTY_W-1:0] right;
    } motor_duty_t;

    localparam logic [DUTY_W-1:0] DUTY_FULL = 10'd1023;
    localparam logic [DUTY_W-1:0] DUTY_SOFT = 10'd700;
    localparam logic [DUTY_W-1:0] DUTY_SLOW = 10'd600;

    // H-bridge direction pair per wheel
    typedef struct packed {
        logic [1:0] left;
        logic [1:0] right;
    } bridge_t;

    localparam logic [1:0] BRIDGE_OFF = 2'b00;
    localparam logic [1:0] BRIDGE_REV = 2'b01;
    localparam logic [1:0] BRIDGE_FWD = 2'b10;

    // PWM counter runs 0 .. PWM_PERIOD-1
    localparam int PWM_PERIOD = 1024;
    localparam int PWM_W = $clog2(PWM_PERIOD);
    localparam logic [PWM_W-1:0] PWM_LAST = PWM_W'(PWM_PERIOD - 1);

    // Samples needed before a filter output follows its input
    localparam int FILTER_LEN = 8;

    // Ranger trigger, short period for simulation
    localparam int TRIG_PERIOD = 4000;
    localparam int TRIG_W = $clog2(TRIG_PERIOD);
    localparam logic [TRIG_W-1:0] TRIG_LAST = TRIG_W'(TRIG_PERIOD - 1);
    localparam logic [TRIG_W-1:0] TRIG_HIGH = TRIG_W'(20);

    // Echo width in system clocks
    localparam int ECHO_W = 12;
    localparam logic [ECHO_W-1:0] ECHO_MAX = 12'd3000;
    // Anything shorter is an obstacle
    localparam logic [ECHO_W-1:0] STOP_ECHO = 12'd800;

endpackage

//--- hw/car_top.sv
module car_top (
    input  logic                   clk,
    input  logic                   rst,
    input  car_pkg::line_sensors_t line,
    input  logic                   echo,
    input  logic                   stop_b,
    output logic                   trig,
    output logic                   pwm_left,
    output logic                   pwm_right,
    output car_pkg::bridge_t       bridge,
    output logic [2:0]             led
);

    car_pkg::line_sensors_t line_f;
    car_pkg::track_mode_t   mode;
    logic                   stop_f;
    logic                   near;

    // LEDs show the unfiltered sensors
    assign led = line;

    sig_filter #(.payload_t(car_pkg::line_sensors_t)) u_line_filt (
        .clk   (clk),
        .rst   (rst),
        .raw   (line),
        .clean (line_f)
    );

    sig_filter #(.payload_t(logic)) u_stop_filt (
        .clk   (clk),
        .rst   (rst),
        .raw   (stop_b),
        .clean (stop_f)
    );

    line_tracker u_tracker (
        .clk    (clk),
        .rst    (rst),
        .line_f (line_f),
        .mode   (mode)
    );

    motor_drive u_drive (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .pwm_left  (pwm_left),
        .pwm_right (pwm_right)
    );

    sonar_ranger u_sonar (
        .clk  (clk),
        .rst  (rst),
        .echo (echo),
        .trig (trig),
        .near (near)
    );

    // Obstacle or button brakes both wheels, PWM keeps running
    always_comb begin
        if (near || stop_f) begin
            bridge = '{left: car_pkg::BRIDGE_OFF, right: car_pkg::BRIDGE_OFF};
        end else begin
            case (mode)
                car_pkg::STAY_L: begin
                    bridge = '{left: car_pkg::BRIDGE_REV, right: car_pkg::BRIDGE_FWD};
                end
                car_pkg::STAY_R: begin
                    bridge = '{left: car_pkg::BRIDGE_FWD, right: car_pkg::BRIDGE_REV};
                end
                default: begin
                    bridge = '{left: car_pkg::BRIDGE_FWD, right: car_pkg::BRIDGE_FWD};
                end
            endcase
        end
    end

endmodule

//--- hw/line_tracker.sv
module line_tracker (
    input  logic                   clk,
    input  logic                   rst,
    input  car_pkg::line_sensors_t line_f,
    output car_pkg::track_mode_t   mode
);

    car_pkg::track_mode_t mode_next;
    logic                 all_on;
    // Pivot memory, 1 when the line was last drifting to the right
    logic                 turn_right;

    assign all_on = line_f.left && line_f.mid && line_f.right;

    always_comb begin
        mode_next = car_pkg::track_mode_t'({1'b0, line_f});
        case (mode)
            car_pkg::FOLLOW_000: begin
                // Line lost, pivot toward the side it was last seen
                if (turn_right) begin
                    mode_next = car_pkg::STAY_R;
                end else begin
                    mode_next = car_pkg::STAY_L;
                end
            end
            car_pkg::STAY_L,
            car_pkg::STAY_R: begin
                // Keep pivoting until all three sensors find the line again
                if (all_on) begin
                    mode_next = car_pkg::FOLLOW_111;
                end else begin
                    mode_next = mode;
                end
            end
            default: begin
                mode_next = car_pkg::track_mode_t'({1'b0, line_f});
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode       <= car_pkg::FOLLOW_111;
            turn_right <= 1'b0;
        end else begin
            mode <= mode_next;
            case (mode)
                car_pkg::FOLLOW_100,
                car_pkg::FOLLOW_110: begin
                    turn_right <= 1'b0;
                end
                car_pkg::FOLLOW_001,
                car_pkg::FOLLOW_011: begin
                    turn_right <= 1'b1;
                end
                default: begin
                    turn_right <= turn_right;
                end
            endcase
        end
    end

    // No jump between pivots and no drop back into a partial pattern
    a_stay_exit: assert property (
        @(posedge clk) disable iff (rst)
        (mode == car_pkg::STAY_L || mode == car_pkg::STAY_R)
            |=> (mode == $past(mode) || mode == car_pkg::FOLLOW_111)
    ) else $error("line_tracker left a STAY mode toward %h", mode);

endmodule

//--- hw/motor_drive.sv
module motor_drive (
    input  logic                 clk,
    input  logic                 rst,
    input  car_pkg::track_mode_t mode,
    output logic                 pwm_left,
    output logic                 pwm_right
);

    car_pkg::motor_duty_t duty;
    car_pkg::motor_duty_t duty_next;

    // Slow the inner wheel on a gentle or sharp curve
    always_comb begin
        case (mode)
            car_pkg::FOLLOW_011: begin
                duty_next = '{left: car_pkg::DUTY_FULL, right: car_pkg::DUTY_SOFT};
            end
            car_pkg::FOLLOW_001: begin
                duty_next = '{left: car_pkg::DUTY_FULL, right: car_pkg::DUTY_SLOW};
            end
            car_pkg::FOLLOW_110: begin
                duty_next = '{left: car_pkg::DUTY_SOFT, right: car_pkg::DUTY_FULL};
            end
            car_pkg::FOLLOW_100: begin
                duty_next = '{left: car_pkg::DUTY_SLOW, right: car_pkg::DUTY_FULL};
            end
            // Pivots get full power, the bridge sets the direction
            default: begin
                duty_next = '{left: car_pkg::DUTY_FULL, right: car_pkg::DUTY_FULL};
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            duty <= '{left: car_pkg::DUTY_FULL, right: car_pkg::DUTY_FULL};
        end else begin
            duty <= duty_next;
        end
    end

    pwm_gen u_pwm_l (
        .clk  (clk),
        .rst  (rst),
        .duty (duty.left),
        .pwm  (pwm_left)
    );

    pwm_gen u_pwm_r (
        .clk  (clk),
        .rst  (rst),
        .duty (duty.right),
        .pwm  (pwm_right)
    );

endmodule

//--- hw/pwm_gen.sv
module pwm_gen (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [car_pkg::DUTY_W-1:0] duty,
    output logic                       pwm
);

    logic [car_pkg::PWM_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
            pwm <= 1'b0;
        end else begin
            if (cnt == car_pkg::PWM_LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            // High for exactly duty counts per period
            pwm <= (cnt < duty);
        end
    end

endmodule

//--- hw/sig_filter.sv
module sig_filter #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t raw,
    output payload_t clean
);

    // hist[0] is the newest sample
    payload_t hist [car_pkg::FILTER_LEN];
    logic     all_same;

    always_comb begin
        all_same = 1'b1;
        for (int i = 1; i < car_pkg::FILTER_LEN; i++) begin
            if (hist[i] != hist[0]) begin
                all_same = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < car_pkg::FILTER_LEN; i++) begin
                hist[i] <= '0;
            end
            clean <= '0;
        end else begin
            hist[0] <= raw;
            for (int i = 1; i < car_pkg::FILTER_LEN; i++) begin
                hist[i] <= hist[i-1];
            end
            if (all_same) begin
                clean <= hist[0];
            end
        end
    end

    // A new output value must have been on raw for every sample behind it
    for (genvar j = 2; j <= car_pkg::FILTER_LEN + 1; j++) begin : g_held
        a_clean_from_raw: assert property (
            @(posedge clk) disable iff (rst)
            $changed(clean) |-> ($past(raw, j) == clean)
        ) else $error("sig_filter output changed without a matching input");
    end

endmodule

//--- hw/sonar_ranger.sv
module sonar_ranger (
    input  logic clk,
    input  logic rst,
    input  logic echo,
    output logic trig,
    output logic near
);

    typedef enum logic [1:0] {
        ECHO_IDLE,
        ECHO_TIMING,
        ECHO_LATCH
    } echo_state_t;

    logic [car_pkg::TRIG_W-1:0] trig_cnt;
    logic                       echo_s1;
    logic                       echo_s2;
    logic                       echo_rise;
    logic                       echo_fall;
    echo_state_t                state;
    logic [car_pkg::ECHO_W-1:0] echo_cnt;
    logic [car_pkg::ECHO_W-1:0] echo_width;

    // Trigger window, pulse at the start of every period
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trig_cnt <= '0;
            trig     <= 1'b0;
        end else begin
            if (trig_cnt == car_pkg::TRIG_LAST) begin
                trig_cnt <= '0;
            end else begin
                trig_cnt <= trig_cnt + 1'b1;
            end
            trig <= (trig_cnt < car_pkg::TRIG_HIGH);
        end
    end

    assign echo_rise = echo_s1 && !echo_s2;
    assign echo_fall = !echo_s1 && echo_s2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            echo_s1  <= 1'b0;
            echo_s2  <= 1'b0;
            state    <= ECHO_IDLE;
            echo_cnt <= '0;
            near     <= 1'b0;
        end else begin
            echo_s1 <= echo;
            echo_s2 <= echo_s1;
            case (state)
                ECHO_IDLE: begin
                    echo_cnt <= '0;
                    if (echo_rise) begin
                        state <= ECHO_TIMING;
                    end
                end
                ECHO_TIMING: begin
                    if (echo_fall) begin
                        state <= ECHO_LATCH;
                    end else if (echo_cnt < car_pkg::ECHO_MAX) begin
                        // Saturates so a missing echo reads as far away
                        echo_cnt <= echo_cnt + 1'b1;
                    end
                end
                ECHO_LATCH: begin
                    near  <= (echo_width < car_pkg::STOP_ECHO);
                    state <= ECHO_IDLE;
                end
                default: begin
                    state <= ECHO_IDLE;
                end
            endcase
        end
    end

    // Width of the last complete echo
    always_ff @(posedge clk) begin
        if (state == ECHO_TIMING && echo_fall) begin
            echo_width <= echo_cnt;
        end
    end

    a_trig_len: assert property (
        @(posedge clk) disable iff (rst)
        trig [*car_pkg::TRIG_HIGH] |=> !trig
    ) else $error("trig held high longer than TRIG_HIGH");

endmodule

//--- tb.f
hw/car_pkg.sv
hw/sig_filter.sv
hw/pwm_gen.sv
hw/line_tracker.sv
hw/motor_drive.sv
hw/sonar_ranger.sv
hw/car_top.sv
test/car_tb.sv

//--- test/car_tb.sv
module car_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;
    localparam int SETTLE = car_pkg::FILTER_LEN + 10;
    localparam int N_STEER = 12;
    localparam int N_LOST = 12;
    localparam int N_GLITCH = 20;
    localparam int N_ECHO = 10;
    localparam int NEAR_MIN = 40;
    localparam int NEAR_MAX = int'(car_pkg::STOP_ECHO) * 4 / 5 - 1;
    localparam int FAR_MIN = int'(car_pkg::STOP_ECHO) * 6 / 5 + 1;
    localparam int FAR_MAX = 2000;
    localparam int HOLD_CYCLES = SETTLE + car_pkg::PWM_PERIOD + 1;
    localparam int GLITCH_CYCLES = car_pkg::FILTER_LEN - 1 + 4 + 1;
    localparam int ECHO_CYCLES = FAR_MAX + 12;
    localparam int PLAN_CYCLES = RESET_CYCLES + (N_STEER + N_LOST + 3) * HOLD_CYCLES
        + N_GLITCH * GLITCH_CYCLES + (N_ECHO + 3) * ECHO_CYCLES + SETTLE + 1;
    localparam int TIMEOUT_CYCLES = PLAN_CYCLES + PLAN_CYCLES / 5;

    logic                   clk;
    logic                   rst;
    car_pkg::line_sensors_t line;
    logic                   echo;
    logic                   stop_b;
    logic                   trig;
    logic                   pwm_left;
    logic                   pwm_right;
    car_pkg::bridge_t       bridge;
    logic [2:0]             led;

    integer                 seed = 32'hc4ab236a;
    int                     cycle_cnt = 0;
    int                     trig_edges = 0;
    car_pkg::line_sensors_t line_cur;

    // Reference state
    car_pkg::track_mode_t   model_mode;
    logic                   model_right;
    logic                   model_near;
    logic                   model_stop;

    car_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .line      (line),
        .echo      (echo),
        .stop_b    (stop_b),
        .trig      (trig),
        .pwm_left  (pwm_left),
        .pwm_right (pwm_right),
        .bridge    (bridge),
        .led       (led)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_bridge(input string name, input car_pkg::bridge_t exp,
                                input car_pkg::bridge_t got);
        if (got !== exp) begin
            fail_now($sformatf("FAILED %s exp %h got %h", name, exp, got));
        end
    endtask

    task automatic check_duty(input string name, input car_pkg::motor_duty_t exp,
                              input car_pkg::motor_duty_t got);
        if (got !== exp) begin
            fail_now($sformatf("FAILED %s exp %h got %h", name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            fail_now($sformatf("FAILED %s exp %h got %h", name, exp, got));
        end
    endtask

    task automatic check_led(input string name, input logic [2:0] exp, input logic [2:0] got);
        if (got !== exp) begin
            fail_now($sformatf("FAILED %s exp %h got %h", name, exp, got));
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic car_pkg::line_sensors_t rand_pattern();
        logic [2:0] b;
        b = 3'(rand_range(0, 7));
        return b;
    endfunction

    // Lost-line runs need plenty of 000 and 111
    function automatic car_pkg::line_sensors_t lost_pattern();
        int r;
        r = rand_range(0, 7);
        if (r < 3) begin
            return 3'b000;
        end else if (r < 5) begin
            return 3'b111;
        end
        return rand_pattern();
    endfunction

    function automatic void model_apply(input car_pkg::line_sensors_t p);
        logic [2:0] bits;
        bits = p;
        if (model_mode == car_pkg::STAY_L || model_mode == car_pkg::STAY_R) begin
            if (bits == 3'b111) begin
                model_mode = car_pkg::FOLLOW_111;
            end
        end else if (bits == 3'b000) begin
            model_mode = model_right ? car_pkg::STAY_R : car_pkg::STAY_L;
        end else begin
            model_mode = car_pkg::track_mode_t'({1'b0, bits});
            if (bits == 3'b100 || bits == 3'b110) begin
                model_right = 1'b0;
            end else if (bits == 3'b001 || bits == 3'b011) begin
                model_right = 1'b1;
            end
        end
    endfunction

    function automatic car_pkg::motor_duty_t exp_duty();
        car_pkg::motor_duty_t d;
        d.left = car_pkg::DUTY_FULL;
        d.right = car_pkg::DUTY_FULL;
        case (model_mode)
            car_pkg::FOLLOW_011: d.right = car_pkg::DUTY_SOFT;
            car_pkg::FOLLOW_001: d.right = car_pkg::DUTY_SLOW;
            car_pkg::FOLLOW_110: d.left = car_pkg::DUTY_SOFT;
            car_pkg::FOLLOW_100: d.left = car_pkg::DUTY_SLOW;
            default: d = d;
        endcase
        return d;
    endfunction

    function automatic car_pkg::bridge_t exp_bridge();
        car_pkg::bridge_t b;
        b.left = 2'b10;
        b.right = 2'b10;
        if (model_near || model_stop) begin
            b.left = 2'b00;
            b.right = 2'b00;
        end else if (model_mode == car_pkg::STAY_L) begin
            b.left = 2'b01;
        end else if (model_mode == car_pkg::STAY_R) begin
            b.right = 2'b01;
        end
        return b;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    // High cycles over one full PWM period
    task automatic measure_duty();
        int                   hi_l;
        int                   hi_r;
        car_pkg::motor_duty_t got;
        hi_l = 0;
        hi_r = 0;
        repeat (car_pkg::PWM_PERIOD) begin
            @(negedge clk);
            if (pwm_left) hi_l++;
            if (pwm_right) hi_r++;
            check_led("led", line, led);
            check_bridge("bridge", exp_bridge(), bridge);
        end
        got.left = hi_l[car_pkg::DUTY_W-1:0];
        got.right = hi_r[car_pkg::DUTY_W-1:0];
        check_duty("duty", exp_duty(), got);
    endtask

    task automatic hold_and_check(input car_pkg::line_sensors_t p);
        tick();
        line = p;
        line_cur = p;
        model_apply(p);
        repeat (SETTLE) tick();
        measure_duty();
    endtask

    task automatic send_echo(input int width);
        tick();
        echo = 1'b1;
        repeat (width) tick();
        echo = 1'b0;
        model_near = (width < int'(car_pkg::STOP_ECHO));
        repeat (10) tick();
        @(negedge clk);
        check_bridge("bridge", exp_bridge(), bridge);
    endtask

    task automatic run_glitches();
        int len;
        int gap;
        for (int i = 0; i < N_GLITCH; i++) begin
            len = rand_range(1, car_pkg::FILTER_LEN - 1);
            gap = rand_range(1, 4);
            tick();
            line = line_cur ^ 3'(rand_range(1, 7));
            repeat (len) begin
                @(negedge clk);
                check_led("led", line, led);
                check_bridge("bridge", exp_bridge(), bridge);
                tick();
            end
            line = line_cur;
            repeat (gap) begin
                @(negedge clk);
                check_led("led", line, led);
                check_bridge("bridge", exp_bridge(), bridge);
            end
        end
        hold_and_check(line_cur);
    endtask

    // Trigger counted from the first edge after reset release
    always @(posedge clk) begin
        if (!rst) begin
            trig_edges <= trig_edges + 1;
        end
    end

    always @(negedge clk) begin
        if (rst || trig_edges == 0) begin
            check_bit("trig", 1'b0, trig);
        end else begin
            check_bit("trig", ((trig_edges - 1) % car_pkg::TRIG_PERIOD)
                              < int'(car_pkg::TRIG_HIGH), trig);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            fail_now($sformatf("Timeout, the run did not finish in %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        rst = 1'b1;
        line = 3'b111;
        line_cur = 3'b111;
        echo = 1'b0;
        stop_b = 1'b0;
        model_mode = car_pkg::FOLLOW_111;
        model_right = 1'b0;
        model_near = 1'b0;
        model_stop = 1'b0;

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_bridge("bridge", exp_bridge(), bridge);
        check_bit("pwm_left", 1'b0, pwm_left);
        check_bit("pwm_right", 1'b0, pwm_right);
        tick();
        rst = 1'b0;

        // Filter output starts clear, so the tracker first sees 000
        model_apply(3'b000);
        model_apply(line);
        repeat (SETTLE) tick();
        measure_duty();

        for (int i = 0; i < N_STEER; i++) begin
            hold_and_check(rand_pattern());
        end
        for (int i = 0; i < N_LOST; i++) begin
            hold_and_check(lost_pattern());
        end
        run_glitches();

        for (int i = 0; i < N_ECHO; i++) begin
            if (rand_range(0, 1) == 1) begin
                send_echo(rand_range(NEAR_MIN, NEAR_MAX));
            end else begin
                send_echo(rand_range(FAR_MIN, FAR_MAX));
            end
        end
        send_echo(rand_range(FAR_MIN, FAR_MAX));

        // Button stop, PWM keeps running underneath
        tick();
        stop_b = 1'b1;
        model_stop = 1'b1;
        hold_and_check(line_cur);
        send_echo(rand_range(NEAR_MIN, NEAR_MAX));
        tick();
        stop_b = 1'b0;
        model_stop = 1'b0;
        repeat (SETTLE) tick();
        @(negedge clk);
        check_bridge("bridge", exp_bridge(), bridge);
        send_echo(rand_range(FAR_MIN, FAR_MAX));

        $display("TB PASSED");
        $finish;
    end

endmodule
